//--- lenet_top.f
source/lenet_pkg.sv
source/frame_scanner.sv
source/window_buffer.sv
source/conv_relu.sv
source/max_pool.sv
source/dense_layer.sv
source/argmax_select.sv
source/lenet_top.sv
tests/lenet_asserts.sv
tests/lenet_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module lenet_tb -Mdir "$build_dir" \
	-f lenet_top.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vlenet_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test FAILED" "$log_file"; then
	exit 1
fi
if ! grep -q "Test OK" "$log_file"; then
	echo "no verdict found in $log_file"
	exit 1
fi
exit 0

//--- source/argmax_select.sv
`timescale 1ns/1ps

module argmax_select (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::score_t [lenet_pkg::num_classes-1:0] scores,
	input  logic scores_valid,
	output lenet_pkg::class_t result_class,	// held until next result
	output lenet_pkg::score_t result_score,
	output logic result_valid	// one cycle pulse
);
	import lenet_pkg::*;

	class_t best_idx;
	score_t best_score;

	// linear scan, strict compare keeps the lowest index on a tie
	always_comb begin
		best_idx = '0;
		best_score = scores[0];
		for (int k = 1; k < num_classes; k++) begin
			if ($signed(scores[k]) > best_score) begin
				best_idx = class_t'(k);
				best_score = scores[k];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
			result_class <= '0;
			result_score <= '0;
		end else begin
			result_valid <= scores_valid;
			if (scores_valid) begin
				result_class <= best_idx;
				result_score <= best_score;
			end
		end
	end

endmodule

//--- source/conv_relu.sv
`timescale 1ns/1ps

module conv_relu (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::pixel_t window [lenet_pkg::kernel_size][lenet_pkg::kernel_size],
	input  logic window_valid,	// window complete this cycle
	output lenet_pkg::act_t conv_value,	// ReLU output
	output logic conv_valid
);
	import lenet_pkg::*;

	int conv_sum;	// full precision dot product
	int biased;
	int relu_out;

	// 25 products, weights are constants per tap
	always_comb begin
		conv_sum = 0;
		for (int r = 0; r < kernel_size; r++) begin
			for (int c = 0; c < kernel_size; c++) begin
				conv_sum += int'(window[r][c]) * kernel_weight(r, c);
			end
		end
	end

	assign biased = conv_sum + int'(conv_bias());
	assign relu_out = (biased < 0) ? 0 : biased;	// clamp negatives

	// value register, only loaded for complete windows
	always_ff @(posedge clk) begin
		if (window_valid) begin
			conv_value <= act_t'(relu_out);	// range fits act_t
		end
	end

	// strobe follows the window by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			conv_valid <= 1'b0;
		end else begin
			conv_valid <= window_valid;
		end
	end

	// conv_value holds between strobes
	// downstream only samples it with conv_valid

endmodule

//--- source/dense_layer.sv
`timescale 1ns/1ps

module dense_layer (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::act_t pool_value,
	input  logic pool_valid,
	output lenet_pkg::score_t [lenet_pkg::num_classes-1:0] scores,	// totals with bias
	output logic scores_valid	// once per frame
);
	import lenet_pkg::*;

	logic [pool_idx_w-1:0] pool_idx;	// which pooled value arrives
	logic last_pool;
	score_t acc [num_classes];	// running sums, no bias yet
	score_t acc_next [num_classes];

	assign last_pool = (pool_idx == pool_idx_w'(pool_count - 1));

	// one multiply per class on each pooled value
	always_comb begin
		for (int k = 0; k < num_classes; k++) begin
			acc_next[k] = acc[k]
				+ score_t'(pool_value) * score_t'(dense_weight(k, int'(pool_idx)));
		end
	end

	// index and accumulators clear after the 16th input
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pool_idx <= '0;
			scores_valid <= 1'b0;
			for (int k = 0; k < num_classes; k++) begin
				acc[k] <= '0;
			end
		end else begin
			scores_valid <= pool_valid && last_pool;
			if (pool_valid) begin
				pool_idx <= last_pool ? '0 : pool_idx + 1'b1;
				for (int k = 0; k < num_classes; k++) begin
					acc[k] <= last_pool ? '0 : acc_next[k];	// ready for next frame
				end
			end
		end
	end

	// release totals with bias on the last input
	always_ff @(posedge clk) begin
		if (pool_valid && last_pool) begin
			for (int k = 0; k < num_classes; k++) begin
				scores[k] <= acc_next[k] + dense_bias(k);
			end
		end
	end

endmodule

//--- source/frame_scanner.sv
`timescale 1ns/1ps

module frame_scanner (
	input  logic clk,
	input  logic arst_n,
	input  logic pixel_valid,	// one pixel accepted per high cycle
	output logic window_valid	// current pixel closes a full 5x5 window
);
	import lenet_pkg::*;

	logic [pos_w-1:0] row;	// row of the pixel on the bus
	logic [pos_w-1:0] col;	// column of the pixel on the bus
	logic last_col;
	logic last_row;

	assign last_col = (col == pos_w'(img_cols - 1));
	assign last_row = (row == pos_w'(img_rows - 1));

	// raster position, advances only on accepted pixels
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			row <= '0;
			col <= '0;
		end else if (pixel_valid) begin
			if (last_col) begin
				col <= '0;
				row <= last_row ? '0 : row + 1'b1;	// wrap at frame end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// needs kernel_size-1 rows above and columns to the left
	assign window_valid = pixel_valid
		&& (row >= pos_w'(kernel_size - 1))
		&& (col >= pos_w'(kernel_size - 1));

endmodule

//--- source/lenet_pkg.sv
package lenet_pkg;

	// frame and layer geometry
	localparam int img_cols = 12;	// pixels per row
	localparam int img_rows = 12;	// rows per frame
	localparam int kernel_size = 5;
	localparam int conv_size = img_cols - kernel_size + 1;	// 8x8 conv map
	localparam int pool_size = conv_size / 2;	// 4x4 after 2x2 pooling
	localparam int pool_count = pool_size * pool_size;	// pooled values per frame
	localparam int num_classes = 4;
	localparam int class_w = $clog2(num_classes);

	// counter widths
	localparam int pos_w = $clog2((img_cols > img_rows) ? img_cols : img_rows);
	localparam int conv_pos_w = $clog2(conv_size);	// conv row / column
	localparam int pool_idx_w = $clog2(pool_count);	// pooled input index

	typedef logic signed [7:0] pixel_t;	// input pixel
	typedef logic signed [15:0] act_t;	// conv, activation and pooled values
	typedef logic signed [31:0] score_t;	// class score
	typedef logic [class_w-1:0] class_t;	// class index

	// 5x5 kernel, values in -4..3
	function automatic int kernel_weight(input int row, input int col);
		return ((row * 3 + col * 5) % 8) - 4;
	endfunction

	// single bias for the one feature map
	// kept negative so a blank frame pools to zero
	function automatic act_t conv_bias();
		return act_t'(-16);
	endfunction

	// fully connected weights, values in -3..3
	function automatic int dense_weight(input int cls, input int idx);
		return ((cls * 5 + idx * 3 + 1) % 7) - 3;
	endfunction

	// class biases
	// classes 1 and 3 share the top value, so a blank frame ties
	function automatic score_t dense_bias(input int cls);
		score_t bias;
		case (cls)
			0: bias = -32'sd20;
			1: bias = 32'sd64;
			2: bias = 32'sd12;
			3: bias = 32'sd64;
			default: bias = '0;
		endcase
		return bias;
	endfunction

	// worst case conv magnitude is 25 * 128 * 4 = 12800
	// so act_t never overflows after ReLU
	// worst case score is 16 * 12800 * 3 plus bias, far below the score_t range

endpackage

//--- source/lenet_top.sv
`timescale 1ns/1ps

module lenet_top (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::pixel_t pixel,	// raster order
	input  logic pixel_valid,
	output logic result_valid,
	output lenet_pkg::class_t result_class,
	output lenet_pkg::score_t result_score
);
	import lenet_pkg::*;

	logic window_valid;
	pixel_t window [kernel_size][kernel_size];	// 5x5 neighbourhood
	act_t conv_value;
	logic conv_valid;
	act_t pool_value;
	logic pool_valid;
	score_t [num_classes-1:0] scores;
	logic scores_valid;

	// pixel position and window ready flag
	frame_scanner i_frame_scanner (
		.clk(clk), .arst_n(arst_n),
		.pixel_valid(pixel_valid),
		.window_valid(window_valid)
	);

	window_buffer i_window_buffer (
		.clk(clk), .arst_n(arst_n),
		.pixel(pixel), .pixel_valid(pixel_valid),
		.window(window)
	);

	conv_relu i_conv_relu (
		.clk(clk), .arst_n(arst_n),
		.window(window), .window_valid(window_valid),
		.conv_value(conv_value), .conv_valid(conv_valid)
	);

	max_pool i_max_pool (
		.clk(clk), .arst_n(arst_n),
		.conv_value(conv_value), .conv_valid(conv_valid),
		.pool_value(pool_value), .pool_valid(pool_valid)
	);

	dense_layer i_dense_layer (
		.clk(clk), .arst_n(arst_n),
		.pool_value(pool_value), .pool_valid(pool_valid),
		.scores(scores), .scores_valid(scores_valid)
	);

	// final class pick
	argmax_select i_argmax_select (
		.clk(clk), .arst_n(arst_n),
		.scores(scores), .scores_valid(scores_valid),
		.result_class(result_class), .result_score(result_score),
		.result_valid(result_valid)
	);

endmodule

//--- source/max_pool.sv
`timescale 1ns/1ps

module max_pool (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::act_t conv_value,
	input  logic conv_valid,
	output lenet_pkg::act_t pool_value,
	output logic pool_valid	// one per 2x2 block
);
	import lenet_pkg::*;

	logic [conv_pos_w-1:0] conv_row;	// position of the incoming conv value
	logic [conv_pos_w-1:0] conv_col;
	logic [conv_pos_w-2:0] pool_col;	// 2x2 block column
	logic pool_end;	// odd row and odd column
	act_t prev_value;	// left neighbour in the same row
	act_t pair_max;
	act_t quad_max;
	act_t row_max [pool_size];	// pair maxima from the even row above

	assign pool_col = conv_col[conv_pos_w-1:1];
	assign pool_end = conv_row[0] && conv_col[0];
	assign pair_max = (conv_value > prev_value) ? conv_value : prev_value;
	assign quad_max = (row_max[pool_col] > pair_max) ? row_max[pool_col] : pair_max;

	// conv map position
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			conv_row <= '0;
			conv_col <= '0;
		end else if (conv_valid) begin
			if (conv_col == conv_pos_w'(conv_size - 1)) begin
				conv_col <= '0;
				conv_row <= (conv_row == conv_pos_w'(conv_size - 1)) ? '0 : conv_row + 1'b1;
			end else begin
				conv_col <= conv_col + 1'b1;
			end
		end
	end

	// pairwise maxima and the pooled result
	always_ff @(posedge clk) begin
		if (conv_valid) begin
			prev_value <= conv_value;
			if (conv_col[0] && !conv_row[0]) begin
				row_max[pool_col] <= pair_max;	// top half of the block
			end
			if (pool_end) begin
				pool_value <= quad_max;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pool_valid <= 1'b0;
		end else begin
			pool_valid <= conv_valid && pool_end;
		end
	end

endmodule

//--- source/window_buffer.sv
`timescale 1ns/1ps

module window_buffer (
	input  logic clk,
	input  logic arst_n,
	input  lenet_pkg::pixel_t pixel,
	input  logic pixel_valid,
	output lenet_pkg::pixel_t window [lenet_pkg::kernel_size][lenet_pkg::kernel_size]
);
	import lenet_pkg::*;

	pixel_t lines [kernel_size-1][img_cols];	// four buffered rows
	pixel_t taps [kernel_size];	// newest column, top row first
	pixel_t cols_q [kernel_size][kernel_size-1];	// four older columns

	// each line is one row deep, its last cell is the pixel one row up
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			lines[0][0] <= pixel;
			for (int k = 1; k < kernel_size - 1; k++) begin
				lines[k][0] <= lines[k-1][img_cols-1];	// cascade into next row up
			end
			for (int k = 0; k < kernel_size - 1; k++) begin
				for (int i = img_cols - 1; i > 0; i--) begin
					lines[k][i] <= lines[k][i-1];
				end
			end
		end
	end

	// live column from the bus and the line outputs
	always_comb begin
		taps[kernel_size-1] = pixel;	// bottom row is the current pixel
		for (int r = 0; r < kernel_size - 1; r++) begin
			taps[r] = lines[kernel_size-2-r][img_cols-1];
		end
	end

	// shift window left by one column per accepted pixel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < kernel_size; r++) begin
				for (int c = 0; c < kernel_size - 1; c++) begin
					cols_q[r][c] <= '0;
				end
			end
		end else if (pixel_valid) begin
			for (int r = 0; r < kernel_size; r++) begin
				for (int c = 0; c < kernel_size - 2; c++) begin
					cols_q[r][c] <= cols_q[r][c+1];
				end
				cols_q[r][kernel_size-2] <= taps[r];
			end
		end
	end

	// rightmost column straight from the taps, rest registered
	always_comb begin
		for (int r = 0; r < kernel_size; r++) begin
			for (int c = 0; c < kernel_size - 1; c++) begin
				window[r][c] = cols_q[r][c];
			end
			window[r][kernel_size-1] = taps[r];
		end
	end

endmodule

//--- tests/lenet_asserts.sv
`timescale 1ns/1ps

module lenet_asserts (
	input logic clk,
	input logic arst_n,
	input logic result_valid,
	input lenet_pkg::class_t result_class,
	input lenet_pkg::score_t result_score,
	input logic pool_valid	// internal strobe of the top level
);

	// each answer is a single cycle pulse
	result_single: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |=> !result_valid)
		else $error("result_valid high on two consecutive cycles");

	// pooled values need an odd row and odd column so they are never adjacent
	pool_single: assert property (@(posedge clk) disable iff (!arst_n)
		pool_valid |=> !pool_valid)
		else $error("pool_valid high on two consecutive cycles");

	// outputs only move together with a result pulse
	result_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!result_valid |-> ($stable(result_class) && $stable(result_score)))
		else $error("result outputs changed without result_valid");

	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !result_valid)
		else $error("result_valid high during reset");

endmodule

bind lenet_top lenet_asserts i_lenet_asserts (
	.clk(clk),
	.arst_n(arst_n),
	.result_valid(result_valid),
	.result_class(result_class),
	.result_score(result_score),
	.pool_valid(pool_valid)
);

//--- tests/lenet_tb.sv
`timescale 1ns/1ps

module lenet_tb;
	import lenet_pkg::*;

	localparam int frame_pixels = img_rows * img_cols;
	localparam int result_latency = 4;	// accept edge to result edge
	localparam int drain_limit = 400;	// cycles allowed for pending results

	logic clk = 1'b0;
	logic arst_n = 1'b0;	// held low from time zero
	pixel_t pixel = '0;
	logic pixel_valid = 1'b0;
	logic result_valid;
	class_t result_class;
	score_t result_score;

	int seed = 32'hc9d693d9;
	pixel_t frame_px [frame_pixels];	// frame about to be sent
	class_t exp_class_q [$];
	score_t exp_score_q [$];
	int accept_q [$];	// cycle of each frame's last accepted pixel
	int cycle_cnt = 0;
	int pix_seen = 0;	// accepted pixels of the current frame
	int results_seen = 0;
	int frames_sent = 0;
	int mismatch_errs = 0;
	int stray_errs = 0;
	int count_errs = 0;
	int timeout_errs = 0;

	lenet_top i_lenet_top (
		.clk(clk),
		.arst_n(arst_n),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.result_valid(result_valid),
		.result_class(result_class),
		.result_score(result_score)
	);

	always #2 clk = ~clk;	// 4 ns period

	// golden model of conv, relu, pool, dense and argmax
	function automatic void predict_frame(input pixel_t img [frame_pixels],
		output class_t best_cls, output score_t best_score);
		int conv_map [conv_size][conv_size];
		int pooled [pool_count];
		score_t sc [num_classes];
		int s;
		int m;
		for (int oy = 0; oy < conv_size; oy++) begin
			for (int ox = 0; ox < conv_size; ox++) begin
				s = 0;
				for (int r = 0; r < kernel_size; r++) begin
					for (int c = 0; c < kernel_size; c++) begin
						s += int'(img[(oy + r) * img_cols + ox + c]) * kernel_weight(r, c);
					end
				end
				s += int'(conv_bias());
				if (s < 0) begin
					s = 0;	// relu
				end
				conv_map[oy][ox] = int'(act_t'(s));
			end
		end
		for (int py = 0; py < pool_size; py++) begin
			for (int px = 0; px < pool_size; px++) begin
				m = conv_map[2 * py][2 * px];
				for (int dy = 0; dy < 2; dy++) begin
					for (int dx = 0; dx < 2; dx++) begin
						if (conv_map[2 * py + dy][2 * px + dx] > m) begin
							m = conv_map[2 * py + dy][2 * px + dx];
						end
					end
				end
				pooled[py * pool_size + px] = m;	// raster order of blocks
			end
		end
		for (int k = 0; k < num_classes; k++) begin
			sc[k] = dense_bias(k);
			for (int i = 0; i < pool_count; i++) begin
				sc[k] += score_t'(pooled[i] * dense_weight(k, i));
			end
		end
		best_cls = '0;
		best_score = sc[0];
		for (int k = 1; k < num_classes; k++) begin
			if (sc[k] > best_score) begin	// ties stay on the lower index
				best_cls = class_t'(k);
				best_score = sc[k];
			end
		end
	endfunction

	task automatic check_class(input string name, input class_t exp, input class_t got);
		if (exp !== got) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			mismatch_errs++;
		end
	endtask

	task automatic check_score(input string name, input score_t exp, input score_t got);
		if (exp !== got) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			mismatch_errs++;
		end
	endtask

	task automatic compare_latency(input string name, input int exp, input int got);
		if (exp != got) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			mismatch_errs++;
		end
	endtask

	task automatic compare_count(input string name, input int exp, input int got);
		if (exp != got) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			count_errs++;
		end
	endtask

	task automatic fill_random_frame();
		for (int i = 0; i < frame_pixels; i++) begin
			frame_px[i] = pixel_t'($random(seed));
		end
	endtask

	task automatic fill_zero_frame();
		for (int i = 0; i < frame_pixels; i++) begin
			frame_px[i] = '0;
		end
	endtask

	task automatic queue_expected(input class_t cls, input score_t score);
		exp_class_q.push_back(cls);
		exp_score_q.push_back(score);
		frames_sent++;
	endtask

	// n_pix below a full frame leaves it unfinished
	task automatic send_frame(input int n_pix, input bit gaps);
		int idle;
		for (int i = 0; i < n_pix; i++) begin
			if (gaps) begin
				idle = $random(seed) & 3;
				repeat (idle) begin
					@(posedge clk);
					pixel_valid <= 1'b0;
					pixel <= pixel_t'($random(seed));	// junk on the bus that the DUT ignores
				end
			end
			@(posedge clk);
			pixel <= frame_px[i];
			pixel_valid <= 1'b1;
		end
	endtask

	task automatic release_bus();
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		pixel_valid <= 1'b0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (results_seen < frames_sent && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		if (results_seen < frames_sent) begin
			$display("timeout at %0t: %0d of %0d results never arrived", $time,
				frames_sent - results_seen, frames_sent);
			timeout_errs++;
		end
	endtask

	// tracks frame ends and checks each result against the oldest frame
	always @(posedge clk) begin : compare_results
		class_t exp_cls;
		score_t exp_score;
		cycle_cnt <= cycle_cnt + 1;
		if (!arst_n) begin
			pix_seen = 0;	// partial frame is dropped
		end else begin
			if (pixel_valid) begin
				if (pix_seen == frame_pixels - 1) begin
					accept_q.push_back(cycle_cnt);
					pix_seen = 0;
				end else begin
					pix_seen = pix_seen + 1;
				end
			end
			if (result_valid) begin
				if (exp_class_q.size() == 0 || accept_q.size() == 0) begin
					$display("error at %0t: result_valid pulsed with no frame pending",
						$time);
					stray_errs++;
				end else begin
					exp_cls = exp_class_q.pop_front();
					exp_score = exp_score_q.pop_front();
					check_class("result_class", exp_cls, result_class);
					check_score("result_score", exp_score, result_score);
					compare_latency("result latency", result_latency,
						cycle_cnt - accept_q.pop_front());
				end
				results_seen <= results_seen + 1;
			end
		end
	end

	initial begin : stimulus
		class_t cls;
		score_t score;
		apply_reset();

		// blank frame ties classes 1 and 3
		fill_zero_frame();
		queue_expected(class_t'(1), dense_bias(1));
		send_frame(frame_pixels, 1'b0);
		release_bus();
		wait_for_results();

		// valid held high inside each frame
		repeat (3) begin
			fill_random_frame();
			predict_frame(frame_px, cls, score);
			queue_expected(cls, score);
			send_frame(frame_pixels, 1'b0);
			release_bus();
			repeat (6) @(posedge clk);
		end
		wait_for_results();

		// random gaps in pixel_valid
		repeat (3) begin
			fill_random_frame();
			predict_frame(frame_px, cls, score);
			queue_expected(cls, score);
			send_frame(frame_pixels, 1'b1);
		end
		release_bus();
		wait_for_results();
		compare_count("result count", frames_sent, results_seen);

		// back to back with no idle cycle between frames
		repeat (4) begin
			fill_random_frame();
			predict_frame(frame_px, cls, score);
			queue_expected(cls, score);
			send_frame(frame_pixels, 1'b0);
		end
		release_bus();
		wait_for_results();

		// reset in mid frame drops the partial frame without an answer
		fill_random_frame();
		send_frame(70, 1'b0);
		apply_reset();
		fill_random_frame();
		predict_frame(frame_px, cls, score);
		queue_expected(cls, score);
		send_frame(frame_pixels, 1'b1);
		release_bus();
		wait_for_results();
		repeat (20) @(posedge clk);	// room for any stray pulse
		compare_count("result count", frames_sent, results_seen);

		$display("%0d frames, %0d results, errors: %0d mismatch %0d stray %0d count %0d timeout",
			frames_sent, results_seen, mismatch_errs, stray_errs, count_errs, timeout_errs);
		if (mismatch_errs + stray_errs + count_errs + timeout_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
